// File: src/tetris_params.svh
`ifndef TETRIS_PARAMS_SVH
`define TETRIS_PARAMS_SVH

// ====================
// Board geometry
// ====================
`define GRID_ROWS 20
`define GRID_COLS 10

// Field widths
`define COL_W    4
`define HEIGHT_W 5
// Cost is 2*height + holes, worst case 59
`define COST_W   7

// Stable samples before a debounced level flips
`define DEBOUNCE_CYCLES 8

`endif

// File: src/tetris_pkg.sv
package tetris_pkg;

  // ====================
  // Game state codes
  // ====================
  // Mirrors the external game FSM encoding
  // Codes not listed are plain play states
  typedef enum logic [3:0] {
    INIT     = 4'd0,
    SPAWN    = 4'd1,
    FALLING  = 4'd2,
    GAMEOVER = 4'd8,
    RESTART  = 4'd9
  } game_state_t;

  // ====================
  // Play mode
  // ====================
  // Who drives the falling piece
  typedef enum logic [1:0] {
    MODE_IDLE,
    MODE_HUMAN,
    MODE_AI
  } play_mode_t;

  // ====================
  // Pixel color
  // ====================
  // One bit each for red, green, blue
  // All zero means the layer is transparent
  typedef logic [2:0] color_t;

endpackage

// File: src/column_feature_if.sv
`timescale 1ns/1ns
`include "tetris_params.svh"

// Per-column features, scanner to picker
interface column_feature_if;

  // One-cycle strobe per column
  logic                 valid;
  // Column index
  logic [`COL_W-1:0]    col;
  // Rows from bottom up to top occupied cell
  logic [`HEIGHT_W-1:0] height;
  // Empty cells under the top occupied cell
  logic [`HEIGHT_W-1:0] holes;
  // Marks the final column of a scan
  logic                 last;

  // Scanner side
  modport source (
    output valid, col, height, holes, last
  );

  // Picker side, no back-pressure
  modport sink (
    input valid, col, height, holes, last
  );

endinterface

// File: src/button_debounce.sv
`timescale 1ns/1ns
`include "tetris_params.svh"

module button_debounce (
  input  logic clk_25m,
  input  logic rst,
  input  logic pb_i,
  output logic level_o
);

  localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

  // Synchronizer stages
  logic sync_1_q;
  logic sync_2_q;
  // Counts samples that disagree with the output
  logic [CNT_W-1:0] stable_cnt_q;

  // Async button into the clock domain
  always_ff @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      sync_1_q <= 1'b0;
      sync_2_q <= 1'b0;
    end else begin
      sync_1_q <= pb_i;
      sync_2_q <= sync_1_q;
    end
  end

  // Level flips only after a full run of equal samples
  always_ff @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      stable_cnt_q <= '0;
      level_o      <= 1'b0;
    end else if (sync_2_q == level_o) begin
      // Glitch ended, start over
      stable_cnt_q <= '0;
    end else if (stable_cnt_q == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
      stable_cnt_q <= '0;
      level_o      <= sync_2_q;
    end else begin
      stable_cnt_q <= stable_cnt_q + 1'b1;
    end
  end

endmodule

// File: src/column_scanner.sv
`timescale 1ns/1ns
`include "tetris_params.svh"

module column_scanner (
  input  logic                               clk_25m,
  input  logic                               rst,
  input  logic                               scan_start_i,
  input  logic [`GRID_ROWS*`GRID_COLS-1:0]   grid_i,
  column_feature_if.source                   feat
);

  // Scan in progress
  logic                 active_q;
  // Column being evaluated this cycle
  logic [`COL_W-1:0]    col_cnt_q;
  logic                 last_col;

  // Features of the current column
  logic [`HEIGHT_W-1:0] height_c;
  logic [`HEIGHT_W-1:0] holes_c;
  logic                 found_c;

  assign last_col = (col_cnt_q == `COL_W'(`GRID_COLS - 1));

  // ====================
  // Column walk
  // ====================
  // Top row first; first hit sets height
  // Every empty cell after that is a hole
  always_comb begin
    height_c = '0;
    holes_c  = '0;
    found_c  = 1'b0;
    for (int r = 0; r < `GRID_ROWS; r++) begin
      if (grid_i[r*`GRID_COLS + col_cnt_q]) begin
        if (!found_c) begin
          found_c  = 1'b1;
          height_c = `HEIGHT_W'(`GRID_ROWS - r);
        end
      end else if (found_c) begin
        holes_c = holes_c + 1'b1;
      end
    end
  end

  // Column counter and strobes
  always_ff @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      active_q   <= 1'b0;
      col_cnt_q  <= '0;
      feat.valid <= 1'b0;
      feat.last  <= 1'b0;
    end else begin
      feat.valid <= active_q;
      feat.last  <= active_q & last_col;
      if (scan_start_i) begin
        // New scan restarts from column 0
        active_q  <= 1'b1;
        col_cnt_q <= '0;
      end else if (active_q) begin
        if (last_col) begin
          active_q <= 1'b0;
        end
        col_cnt_q <= last_col ? '0 : col_cnt_q + 1'b1;
      end
    end
  end

  // Feature payload
  always_ff @(posedge clk_25m) begin
    feat.col    <= col_cnt_q;
    feat.height <= height_c;
    feat.holes  <= holes_c;
  end

endmodule

// File: src/placement_picker.sv
`timescale 1ns/1ns
`include "tetris_params.svh"

module placement_picker (
  input  logic              clk_25m,
  input  logic              rst,
  input  logic              scan_start_i,
  column_feature_if.sink    feat,
  input  logic [`COL_W-1:0] falling_x_i,
  output logic [`COL_W-1:0] target_col_o,
  output logic              target_valid_o,
  output logic              steer_left_o,
  output logic              steer_right_o
);

  // Running minimum over the scan
  logic [`COST_W-1:0] best_cost_q;
  logic [`COL_W-1:0]  best_col_q;

  // Cost of the incoming column
  logic [`COST_W-1:0] cost_c;
  logic               take_c;
  logic [`COL_W-1:0]  win_col_c;

  // Tall columns weigh double
  assign cost_c = (`COST_W'(feat.height) << 1) + `COST_W'(feat.holes);

  // Strict compare, so a tie keeps the lower index
  assign take_c    = (cost_c < best_cost_q);
  assign win_col_c = take_c ? feat.col : best_col_q;

  // ====================
  // Minimum tracking
  // ====================
  always_ff @(posedge clk_25m) begin
    if (scan_start_i) begin
      // All ones beats any real cost
      best_cost_q <= '1;
      best_col_q  <= '0;
    end else if (feat.valid && take_c) begin
      best_cost_q <= cost_c;
      best_col_q  <= feat.col;
    end
  end

  // Target latched on the last column
  always_ff @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      target_valid_o <= 1'b0;
      target_col_o   <= '0;
    end else if (scan_start_i) begin
      target_valid_o <= 1'b0;
    end else if (feat.valid && feat.last) begin
      target_valid_o <= 1'b1;
      target_col_o   <= win_col_c;
    end
  end

  // Steer toward the target; idle when aligned
  assign steer_right_o = target_valid_o & (falling_x_i < target_col_o);
  assign steer_left_o  = target_valid_o & (falling_x_i > target_col_o);

endmodule

// File: src/play_mode_ctrl.sv
`timescale 1ns/1ns

module play_mode_ctrl (
  input  logic                     clk_25m,
  input  logic                     rst,
  input  tetris_pkg::game_state_t  game_state_i,
  input  logic                     human_start_i,
  input  logic                     ai_start_i,
  input  logic                     spawn_i,
  input  logic                     speed_btn_i,
  input  logic                     right_i,
  input  logic                     left_i,
  input  logic                     rot_r_i,
  input  logic                     rot_l_i,
  input  logic                     steer_left_i,
  input  logic                     steer_right_i,
  output tetris_pkg::play_mode_t   mode_o,
  output logic                     scan_start_o,
  output logic                     move_right_o,
  output logic                     move_left_o,
  output logic                     rotate_r_o,
  output logic                     rotate_l_o,
  output logic                     speed_up_o
);

  tetris_pkg::play_mode_t mode_d;
  logic                   start_ok;
  logic                   game_over;

  // Starts only accepted before a game begins
  assign start_ok  = (game_state_i == tetris_pkg::INIT) ||
                     (game_state_i == tetris_pkg::RESTART);
  assign game_over = (game_state_i == tetris_pkg::GAMEOVER);

  // ====================
  // Mode FSM
  // ====================
  always_comb begin
    mode_d = mode_o;
    case (mode_o)
      tetris_pkg::MODE_IDLE: begin
        // AI wins when both are pressed
        if (start_ok && ai_start_i) begin
          mode_d = tetris_pkg::MODE_AI;
        end else if (start_ok && human_start_i) begin
          mode_d = tetris_pkg::MODE_HUMAN;
        end
      end
      tetris_pkg::MODE_HUMAN,
      tetris_pkg::MODE_AI: begin
        if (game_over) begin
          mode_d = tetris_pkg::MODE_IDLE;
        end
      end
      default: mode_d = tetris_pkg::MODE_IDLE;
    endcase
  end

  always_ff @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      mode_o <= tetris_pkg::MODE_IDLE;
    end else begin
      mode_o <= mode_d;
    end
  end

  // Kick the column scan on each AI spawn
  always_ff @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      scan_start_o <= 1'b0;
    end else begin
      scan_start_o <= spawn_i & (mode_o == tetris_pkg::MODE_AI);
    end
  end

  // ====================
  // Move source select
  // ====================
  always_comb begin
    move_right_o = 1'b0;
    move_left_o  = 1'b0;
    rotate_r_o   = 1'b0;
    rotate_l_o   = 1'b0;
    speed_up_o   = 1'b0;
    if (!game_over) begin
      case (mode_o)
        // Right button doubles as restart request
        tetris_pkg::MODE_IDLE: begin
          move_right_o = right_i;
        end
        tetris_pkg::MODE_HUMAN: begin
          move_right_o = right_i;
          move_left_o  = left_i;
          rotate_r_o   = rot_r_i;
          rotate_l_o   = rot_l_i;
          speed_up_o   = speed_btn_i;
        end
        tetris_pkg::MODE_AI: begin
          // No rotation search, drop at full speed
          move_right_o = steer_right_i;
          move_left_o  = steer_left_i;
          speed_up_o   = 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

// File: src/layer_color_mux.sv
`timescale 1ns/1ns

module layer_color_mux (
  input  tetris_pkg::color_t overlay_i,
  input  tetris_pkg::color_t score_i,
  input  tetris_pkg::color_t preview_i,
  input  tetris_pkg::color_t credits_i,
  input  tetris_pkg::color_t board_i,
  output tetris_pkg::color_t pixel_o
);

  // First opaque layer wins
  // Board shows through when all overlays are clear
  always_comb begin
    if (overlay_i != '0) begin
      pixel_o = overlay_i;
    end else if (score_i != '0) begin
      pixel_o = score_i;
    end else if (preview_i != '0) begin
      // Next-piece window
      pixel_o = preview_i;
    end else if (credits_i != '0) begin
      pixel_o = credits_i;
    end else begin
      pixel_o = board_i;
    end
  end

endmodule

// File: src/tetris_ai_player_top.sv
`timescale 1ns/1ns
`include "tetris_params.svh"

module tetris_ai_player_top (
  input  logic                             clk_25m,
  input  logic                             rst,
  input  logic                             btn_right_i,
  input  logic                             btn_left_i,
  input  logic                             btn_rot_r_i,
  input  logic                             btn_rot_l_i,
  input  logic                             btn_speed_i,
  input  logic                             human_start_i,
  input  logic                             ai_start_i,
  input  logic                             spawn_i,
  input  logic [3:0]                       game_state_i,
  input  logic [`COL_W-1:0]                falling_x_i,
  input  logic [`GRID_ROWS*`GRID_COLS-1:0] grid_i,
  input  tetris_pkg::color_t               overlay_i,
  input  tetris_pkg::color_t               score_i,
  input  tetris_pkg::color_t               preview_i,
  input  tetris_pkg::color_t               credits_i,
  input  tetris_pkg::color_t               board_i,
  output tetris_pkg::play_mode_t           mode_o,
  output logic                             move_right_o,
  output logic                             move_left_o,
  output logic                             rotate_r_o,
  output logic                             rotate_l_o,
  output logic                             speed_up_o,
  output logic [`COL_W-1:0]                ai_target_col_o,
  output logic                             ai_target_valid_o,
  output tetris_pkg::color_t               pixel_o
);

  // Debounced button levels
  logic right_lvl;
  logic left_lvl;
  logic rot_r_lvl;
  logic rot_l_lvl;

  // AI path
  logic scan_start;
  logic steer_left;
  logic steer_right;

  column_feature_if i_feat ();

  // ====================
  // Buttons
  // ====================
  button_debounce i_db_right (.clk_25m, .rst, .pb_i(btn_right_i), .level_o(right_lvl));
  button_debounce i_db_left  (.clk_25m, .rst, .pb_i(btn_left_i),  .level_o(left_lvl));
  button_debounce i_db_rot_r (.clk_25m, .rst, .pb_i(btn_rot_r_i), .level_o(rot_r_lvl));
  button_debounce i_db_rot_l (.clk_25m, .rst, .pb_i(btn_rot_l_i), .level_o(rot_l_lvl));

  // ====================
  // Mode and moves
  // ====================
  play_mode_ctrl i_play_mode_ctrl (
    .clk_25m,
    .rst,
    .game_state_i  (tetris_pkg::game_state_t'(game_state_i)),
    .human_start_i,
    .ai_start_i,
    .spawn_i,
    .speed_btn_i   (btn_speed_i),
    .right_i       (right_lvl),
    .left_i        (left_lvl),
    .rot_r_i       (rot_r_lvl),
    .rot_l_i       (rot_l_lvl),
    .steer_left_i  (steer_left),
    .steer_right_i (steer_right),
    .mode_o,
    .scan_start_o  (scan_start),
    .move_right_o,
    .move_left_o,
    .rotate_r_o,
    .rotate_l_o,
    .speed_up_o
  );

  // Board features, one column per clock
  column_scanner i_column_scanner (
    .clk_25m,
    .rst,
    .scan_start_i (scan_start),
    .grid_i,
    .feat         (i_feat.source)
  );

  // Best column and steering
  placement_picker i_placement_picker (
    .clk_25m,
    .rst,
    .scan_start_i   (scan_start),
    .feat           (i_feat.sink),
    .falling_x_i,
    .target_col_o   (ai_target_col_o),
    .target_valid_o (ai_target_valid_o),
    .steer_left_o   (steer_left),
    .steer_right_o  (steer_right)
  );

  // Display layering
  layer_color_mux i_layer_color_mux (
    .overlay_i,
    .score_i,
    .preview_i,
    .credits_i,
    .board_i,
    .pixel_o
  );

endmodule

// File: testbench/tb_tetris_ai_player.sv
`timescale 1ns/1ns
`include "tetris_params.svh"

module tb_tetris_ai_player;

  localparam int GRID_BITS = `GRID_ROWS * `GRID_COLS;

  logic                     clk_25m;
  logic                     rst;
  // Buttons: 0 right, 1 left, 2 rotate right, 3 rotate left
  logic [3:0]               btn;
  logic                     btn_speed;
  logic                     human_start;
  logic                     ai_start;
  logic                     spawn;
  logic [3:0]               game_state;
  logic [`COL_W-1:0]        falling_x;
  logic [GRID_BITS-1:0]     grid;
  // Layers: overlay, score, preview, credits, board
  tetris_pkg::color_t       layer [5];

  tetris_pkg::play_mode_t   mode;
  // Moves: right, left, rotate right, rotate left, speed
  logic [4:0]               moves;
  logic [`COL_W-1:0]        target_col;
  logic                     target_valid;
  tetris_pkg::color_t       pixel;

  // Reference model state
  integer                   seed;
  logic                     checks_on;
  logic [3:0]               sync_1;
  logic [3:0]               sync_2;
  logic [3:0]               lvl;
  int                       stable_cnt [4];
  tetris_pkg::play_mode_t   exp_mode;
  int                       scan_age;
  logic                     exp_valid;
  logic [`COL_W-1:0]        exp_col;
  logic [4:0]               exp_moves;
  tetris_pkg::color_t       exp_pixel;

  tetris_ai_player_top i_tetris_ai_player_top (
    .clk_25m,
    .rst,
    .btn_right_i       (btn[0]),
    .btn_left_i        (btn[1]),
    .btn_rot_r_i       (btn[2]),
    .btn_rot_l_i       (btn[3]),
    .btn_speed_i       (btn_speed),
    .human_start_i     (human_start),
    .ai_start_i        (ai_start),
    .spawn_i           (spawn),
    .game_state_i      (game_state),
    .falling_x_i       (falling_x),
    .grid_i            (grid),
    .overlay_i         (layer[0]),
    .score_i           (layer[1]),
    .preview_i         (layer[2]),
    .credits_i         (layer[3]),
    .board_i           (layer[4]),
    .mode_o            (mode),
    .move_right_o      (moves[4]),
    .move_left_o       (moves[3]),
    .rotate_r_o        (moves[2]),
    .rotate_l_o        (moves[1]),
    .speed_up_o        (moves[0]),
    .ai_target_col_o   (target_col),
    .ai_target_valid_o (target_valid),
    .pixel_o           (pixel)
  );

  // 25 MHz board clock
  always #20 clk_25m = ~clk_25m;

  // ====================
  // Reference model
  // ====================
  // Best column by the cost rule, scanned bottom up
  function automatic logic [`COL_W-1:0] best_column(input logic [GRID_BITS-1:0] g);
    int h;
    int filled;
    int cost;
    int best_cost;
    logic [`COL_W-1:0] best;
    best_cost = 1000;
    best = '0;
    for (int c = 0; c < `GRID_COLS; c++) begin
      h = 0;
      filled = 0;
      for (int r = `GRID_ROWS - 1; r >= 0; r--) begin
        if (g[r*`GRID_COLS + c]) begin
          filled++;
          h = `GRID_ROWS - r;
        end
      end
      // Holes are the empty cells under the top
      cost = 2 * h + (h - filled);
      if (cost < best_cost) begin
        best_cost = cost;
        best = `COL_W'(c);
      end
    end
    return best;
  endfunction

  always @(posedge clk_25m or posedge rst) begin
    if (rst) begin
      sync_1    <= '0;
      sync_2    <= '0;
      lvl       <= '0;
      for (int i = 0; i < 4; i++) stable_cnt[i] <= 0;
      exp_mode  <= tetris_pkg::MODE_IDLE;
      scan_age  <= 0;
      exp_valid <= 1'b0;
      exp_col   <= '0;
    end else begin
      sync_1 <= btn;
      sync_2 <= sync_1;
      // Level flips after DEBOUNCE_CYCLES differing samples in a row
      for (int i = 0; i < 4; i++) begin
        if (sync_2[i] == lvl[i]) begin
          stable_cnt[i] <= 0;
        end else if (stable_cnt[i] + 1 == `DEBOUNCE_CYCLES) begin
          lvl[i]        <= sync_2[i];
          stable_cnt[i] <= 0;
        end else begin
          stable_cnt[i] <= stable_cnt[i] + 1;
        end
      end
      // Mode rule
      if (exp_mode == tetris_pkg::MODE_IDLE) begin
        if (game_state == tetris_pkg::INIT || game_state == tetris_pkg::RESTART) begin
          if (ai_start) exp_mode <= tetris_pkg::MODE_AI;
          else if (human_start) exp_mode <= tetris_pkg::MODE_HUMAN;
        end
      end else if (game_state == tetris_pkg::GAMEOVER) begin
        exp_mode <= tetris_pkg::MODE_IDLE;
      end
      // Target due GRID_COLS+2 clocks after the sampled spawn
      if (spawn && exp_mode == tetris_pkg::MODE_AI) begin
        scan_age <= 1;
      end else if (scan_age != 0) begin
        scan_age <= (scan_age == `GRID_COLS + 2) ? 0 : scan_age + 1;
      end
      if (scan_age == 1) exp_valid <= 1'b0;
      if (scan_age == `GRID_COLS + 2) begin
        exp_valid <= 1'b1;
        exp_col   <= best_column(grid);
      end
    end
  end

  // Expected move outputs
  always_comb begin
    exp_moves = '0;
    if (game_state != tetris_pkg::GAMEOVER) begin
      case (exp_mode)
        tetris_pkg::MODE_IDLE:  exp_moves[4] = lvl[0];
        tetris_pkg::MODE_HUMAN: exp_moves = {lvl[0], lvl[1], lvl[2], lvl[3], btn_speed};
        tetris_pkg::MODE_AI: begin
          exp_moves[4] = exp_valid && (falling_x < exp_col);
          exp_moves[3] = exp_valid && (falling_x > exp_col);
          exp_moves[0] = 1'b1;
        end
        default: exp_moves = '0;
      endcase
    end
  end

  // Walk from the lowest layer up, so the topmost opaque one remains
  always_comb begin
    exp_pixel = layer[4];
    for (int i = 3; i >= 0; i--) begin
      if (layer[i] != '0) exp_pixel = layer[i];
    end
  end

  // ====================
  // Checks
  // ====================
  task automatic report_fail(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "check failed");
  endtask

  a_mode: assert property (@(posedge clk_25m) checks_on |-> (mode == exp_mode))
    else report_fail("mode_o differs from the expected mode");
  a_moves: assert property (@(posedge clk_25m) checks_on |-> (moves == exp_moves))
    else report_fail("move outputs differ from the expected moves");
  a_valid: assert property (@(posedge clk_25m) checks_on |-> (target_valid == exp_valid))
    else report_fail("ai_target_valid_o has the wrong timing");
  a_col: assert property (@(posedge clk_25m) (checks_on && exp_valid) |-> (target_col == exp_col))
    else report_fail("ai_target_col_o is not the lowest-cost column");
  a_pixel: assert property (@(posedge clk_25m) checks_on |-> (pixel == exp_pixel))
    else report_fail("pixel_o has the wrong layer priority");

  // ====================
  // Stimulus helpers
  // ====================
  task automatic tick(input int n);
    repeat (n) @(negedge clk_25m);
  endtask

  function automatic bit cond_met(input int sel);
    case (sel)
      0:       return target_valid;
      1:       return moves[4];
      default: return moves == '0;
    endcase
  endfunction

  task automatic wait_for(input int sel, input int limit, input string what);
    int n;
    n = 0;
    while (!cond_met(sel) && n < limit) begin
      @(negedge clk_25m);
      n++;
    end
    if (!cond_met(sel)) begin
      $display("Timeout: %s did not happen within %0d clocks", what, limit);
      $display("*** TEST FAILED ***");
      $fatal(1, "wait timed out");
    end
  endtask

  // Random column stacks, short ones so ties show up
  task automatic load_grid(input bit empty);
    int h;
    grid = '0;
    for (int c = 0; c < `GRID_COLS && !empty; c++) begin
      h = $unsigned($random(seed)) % 8;
      for (int r = `GRID_ROWS - h; r < `GRID_ROWS; r++) begin
        grid[r*`GRID_COLS + c] = (r == `GRID_ROWS - h) || ($random(seed) % 2 != 0);
      end
    end
  endtask

  initial begin
    seed        = 32'h40d0_166d;
    clk_25m     = 1'b0;
    rst         = 1'b1;
    checks_on   = 1'b0;
    btn         = '0;
    btn_speed   = 1'b0;
    human_start = 1'b0;
    ai_start    = 1'b0;
    spawn       = 1'b0;
    game_state  = tetris_pkg::INIT;
    falling_x   = '0;
    grid        = '0;
    for (int i = 0; i < 5; i++) layer[i] = '0;
    @(negedge clk_25m);
    checks_on = 1'b1;
    tick(3);
    rst = 1'b0;

    // Idle lets only the right button through
    btn       = 4'b1111;
    btn_speed = 1'b1;
    wait_for(1, 20, "move_right_o in idle");
    tick(4);
    btn       = '0;
    btn_speed = 1'b0;
    wait_for(2, 20, "release of the idle buttons");

    // Starts outside INIT and RESTART
    game_state  = tetris_pkg::FALLING;
    ai_start    = 1'b1;
    human_start = 1'b1;
    tick(2);
    ai_start    = 1'b0;
    human_start = 1'b0;

    // Human play in a plain play state
    game_state  = tetris_pkg::INIT;
    human_start = 1'b1;
    tick(1);
    human_start = 1'b0;
    game_state  = 4'd5;
    btn = 4'b1111;
    tick(`DEBOUNCE_CYCLES - 2);
    btn = '0;
    tick(12);
    btn       = 4'b1111;
    btn_speed = 1'b1;
    wait_for(1, 20, "move_right_o in human mode");
    tick(6);
    btn       = '0;
    btn_speed = 1'b0;
    wait_for(2, 20, "release of the human buttons");

    // Game over with buttons held
    btn       = 4'b1111;
    btn_speed = 1'b1;
    wait_for(1, 20, "move_right_o before game over");
    game_state = tetris_pkg::GAMEOVER;
    tick(3);
    btn       = '0;
    btn_speed = 1'b0;
    tick(12);

    // Both starts at once, AI must win
    game_state  = tetris_pkg::RESTART;
    ai_start    = 1'b1;
    human_start = 1'b1;
    tick(1);
    ai_start    = 1'b0;
    human_start = 1'b0;
    game_state  = tetris_pkg::SPAWN;
    tick(1);
    // Buttons held, the AI ignores them
    btn = 4'b1111;
    for (int g = 0; g < 6; g++) begin
      load_grid(g == 0);
      spawn = 1'b1;
      tick(1);
      spawn = 1'b0;
      tick(1);
      wait_for(0, 20, "ai_target_valid_o after spawn");
      // Sweep the piece left of, onto and right of the target
      for (int x = 0; x < `GRID_COLS; x++) begin
        falling_x = `COL_W'(x);
        tick(1);
      end
    end
    btn = '0;

    // Color layers, about half of them transparent
    for (int n = 0; n < 40; n++) begin
      for (int i = 0; i < 5; i++) begin
        layer[i] = ($random(seed) % 2 == 0) ? '0 : tetris_pkg::color_t'($random(seed));
      end
      tick(1);
    end

    tick(2);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: list.f
+incdir+src
src/tetris_pkg.sv
src/column_feature_if.sv
src/button_debounce.sv
src/column_scanner.sv
src/placement_picker.sv
src/play_mode_ctrl.sv
src/layer_color_mux.sv
src/tetris_ai_player_top.sv
testbench/tb_tetris_ai_player.sv

// File: Bender.yml
package:
  name: tetris_ai_player

sources:
  - include_dirs:
      - src
    files:
      - src/tetris_pkg.sv
      - src/column_feature_if.sv
      - src/button_debounce.sv
      - src/column_scanner.sv
      - src/placement_picker.sv
      - src/play_mode_ctrl.sv
      - src/layer_color_mux.sv
      - src/tetris_ai_player_top.sv
      - target: test
        files:
          - testbench/tb_tetris_ai_player.sv
